/* build.f */
+incdir+include
verilog/mem_axil_pkg.sv
verilog/mem_two_fifo.sv
verilog/axil_write_issuer.sv
verilog/axil_read_issuer.sv
verilog/mem_txn_tracker.sv
verilog/mem_axil_master.sv
sim/axil_mem_model.sv
sim/tb_mem_axil_master.sv

/* include/mem_axil_cfg.svh */
`ifndef MEM_AXIL_CFG_SVH
`define MEM_AXIL_CFG_SVH

// AXI4-Lite address bus width
`define MEM_AXIL_ADDR_WIDTH 32

// AXI4-Lite data bus width, also the stream data word
`define MEM_AXIL_DATA_WIDTH 32

// Depth of the slave model and the shadow memory, in words
`define MEM_AXIL_MODEL_WORDS 64

`endif

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
# The simulator's exit status is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_mem_axil_master \
  -f build.f

./obj_dir/Vtb_mem_axil_master

/* sim/axil_mem_model.sv */
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module axil_mem_model
  import mem_axil_pkg::*;
  (
    input                clk_i
    , input              reset_i

    , input axil_aw_s    aw_i
    , input              awvalid_i
    , output logic       awready_o

    , input axil_w_s     w_i
    , input              wvalid_i
    , output logic       wready_o

    , output logic [1:0] bresp_o
    , output logic       bvalid_o
    , input              bready_i

    , input axil_aw_s    ar_i
    , input              arvalid_i
    , output logic       arready_o

    , output axil_r_s    r_o
    , output logic       rvalid_o
    , input              rready_i
  );

  localparam int bytes_lp = `MEM_AXIL_MODEL_WORDS * 4;
  localparam int idx_width_lp = $clog2(bytes_lp);

  logic [7:0] mem_r [bytes_lp];
  axil_aw_s aw_r;
  axil_w_s w_r;
  axil_aw_s ar_r;
  logic aw_got_r;
  logic w_got_r;
  logic b_pend_r;
  logic r_pend_r;
  logic [1:0] b_wait_r;
  logic [1:0] r_wait_r;
  logic [idx_width_lp-3:0] aw_word_li;
  logic [idx_width_lp-3:0] ar_word_li;

  assign aw_word_li = aw_r.addr[idx_width_lp-1:2];
  assign ar_word_li = ar_r.addr[idx_width_lp-1:2];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      bresp_o   <= 2'b00;
      rvalid_o  <= 1'b0;
      r_o       <= '0;
      aw_got_r  <= 1'b0;
      w_got_r   <= 1'b0;
      b_pend_r  <= 1'b0;
      r_pend_r  <= 1'b0;
      // Odd multiplier, so every byte address gets its own value
      for (int a = 0; a < bytes_lp; a++)
        mem_r[a] <= 8'(a * 29 + 7);
    end
    else
    begin
      // Random stalls on every ready line
      awready_o <= ($urandom_range(2) != 0);
      wready_o  <= ($urandom_range(2) != 0);
      arready_o <= ($urandom_range(2) != 0);

      if (awvalid_i & awready_o)
      begin
        aw_r     <= aw_i;
        aw_got_r <= 1'b1;
      end
      if (wvalid_i & wready_o)
      begin
        w_r     <= w_i;
        w_got_r <= 1'b1;
      end

      // Address and data both in hand, commit the strobed bytes
      if (aw_got_r & w_got_r)
      begin
        for (int i = 0; i < axil_strb_width_lp; i++)
          if (w_r.strb[i])
            mem_r[{aw_word_li, 2'(i)}] <= w_r.data[8*i +: 8];
        aw_got_r <= 1'b0;
        w_got_r  <= 1'b0;
        b_pend_r <= 1'b1;
        b_wait_r <= 2'($urandom_range(3));
      end
      if (b_pend_r)
      begin
        if (b_wait_r == 2'd0)
        begin
          bvalid_o <= 1'b1;
          b_pend_r <= 1'b0;
        end
        else
          b_wait_r <= b_wait_r - 2'd1;
      end
      if (bvalid_o & bready_i)
        bvalid_o <= 1'b0;

      if (arvalid_i & arready_o)
      begin
        ar_r     <= ar_i;
        r_pend_r <= 1'b1;
        r_wait_r <= 2'($urandom_range(3));
      end
      if (r_pend_r)
      begin
        if (r_wait_r == 2'd0)
        begin
          rvalid_o <= 1'b1;
          r_pend_r <= 1'b0;
          r_o.data <= {mem_r[{ar_word_li, 2'd3}], mem_r[{ar_word_li, 2'd2}],
                       mem_r[{ar_word_li, 2'd1}], mem_r[{ar_word_li, 2'd0}]};
          r_o.resp <= 2'b00;
        end
        else
          r_wait_r <= r_wait_r - 2'd1;
      end
      if (rvalid_o & rready_i)
        rvalid_o <= 1'b0;
    end
  end

endmodule

/* sim/tb_mem_axil_master.sv */
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module tb_mem_axil_master
  import mem_axil_pkg::*;
  ();

  localparam int clk_period_lp = 20;
  localparam int dw_lp = `MEM_AXIL_DATA_WIDTH;
  localparam int aw_lp = `MEM_AXIL_ADDR_WIDTH;
  localparam int mem_bytes_lp = `MEM_AXIL_MODEL_WORDS * 4;
  localparam int random_entries_lp = 24;

  // One table row with expected data taken from the shadow memory
  typedef struct packed
  {
    mem_header_s      header;
    logic [dw_lp-1:0] wdata;
    logic [dw_lp-1:0] exp_data;
  } stim_entry_s;

  logic clk = 1'b0;
  logic reset;

  mem_fwd_s mem_fwd;
  logic mem_fwd_v;
  logic mem_fwd_ready;
  mem_rev_s mem_rev;
  logic mem_rev_v;
  logic mem_rev_ready;

  axil_aw_s axil_aw;
  logic axil_awvalid;
  logic axil_awready;
  axil_w_s axil_w;
  logic axil_wvalid;
  logic axil_wready;
  logic [1:0] axil_bresp;
  logic axil_bvalid;
  logic axil_bready;
  axil_aw_s axil_ar;
  logic axil_arvalid;
  logic axil_arready;
  axil_r_s axil_r;
  logic axil_rvalid;
  logic axil_rready;

  logic [7:0] shadow_mem [mem_bytes_lp];
  stim_entry_s stim_q [$];
  logic rev_done;
  int addr_count;
  int seed_value;
  int watchdog_ns;

  always #(clk_period_lp / 2) clk = ~clk;

  mem_axil_master dut
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.mem_fwd_i(mem_fwd)
     ,.mem_fwd_v_i(mem_fwd_v)
     ,.mem_fwd_ready_o(mem_fwd_ready)
     ,.mem_rev_o(mem_rev)
     ,.mem_rev_v_o(mem_rev_v)
     ,.mem_rev_ready_i(mem_rev_ready)
     ,.m_axil_aw_o(axil_aw)
     ,.m_axil_awvalid_o(axil_awvalid)
     ,.m_axil_awready_i(axil_awready)
     ,.m_axil_w_o(axil_w)
     ,.m_axil_wvalid_o(axil_wvalid)
     ,.m_axil_wready_i(axil_wready)
     ,.m_axil_bresp_i(axil_bresp)
     ,.m_axil_bvalid_i(axil_bvalid)
     ,.m_axil_bready_o(axil_bready)
     ,.m_axil_ar_o(axil_ar)
     ,.m_axil_arvalid_o(axil_arvalid)
     ,.m_axil_arready_i(axil_arready)
     ,.m_axil_r_i(axil_r)
     ,.m_axil_rvalid_i(axil_rvalid)
     ,.m_axil_rready_o(axil_rready)
     );

  axil_mem_model mem_model
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.aw_i(axil_aw)
     ,.awvalid_i(axil_awvalid)
     ,.awready_o(axil_awready)
     ,.w_i(axil_w)
     ,.wvalid_i(axil_wvalid)
     ,.wready_o(axil_wready)
     ,.bresp_o(axil_bresp)
     ,.bvalid_o(axil_bvalid)
     ,.bready_i(axil_bready)
     ,.ar_i(axil_ar)
     ,.arvalid_i(axil_arvalid)
     ,.arready_o(axil_arready)
     ,.r_o(axil_r)
     ,.rvalid_o(axil_rvalid)
     ,.rready_i(axil_rready)
     );

  task automatic abort_run;
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_rev_header(input mem_header_s expected, input mem_header_s actual);
    if (actual !== expected)
    begin
      $display("Fail at %0t: mem_rev_o.header expected %h actual %h",
               $time, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_rev_data(input logic [dw_lp-1:0] expected,
                                input logic [dw_lp-1:0] actual);
    if (actual !== expected)
    begin
      $display("Fail at %0t: mem_rev_o.data expected %h actual %h",
               $time, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_axil_addr(input string name, input axil_aw_s expected,
                                 input axil_aw_s actual);
    if (actual !== expected)
    begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Each request issues exactly one AW or AR in table order
  task automatic match_addr_handshake(input string name, input mem_msg_type_e kind,
                                      input axil_aw_s actual);
    axil_aw_s expected;
    if (addr_count >= stim_q.size() || stim_q[addr_count].header.msg_type != kind)
    begin
      $display("Error at %0t: the %s handshake does not belong to the next request",
               $time, name);
      abort_run();
    end
    expected.addr = stim_q[addr_count].header.addr;
    expected.prot = 3'b000;
    check_axil_addr(name, expected, actual);
    addr_count++;
  endtask

  always @(negedge clk)
  begin
    if (axil_awvalid && axil_awready)
      match_addr_handshake("m_axil_aw_o", e_mem_wr, axil_aw);
    if (axil_arvalid && axil_arready)
      match_addr_handshake("m_axil_ar_o", e_mem_rd, axil_ar);
  end

  function automatic int size_bytes(input mem_msg_size_e size);
    case (size)
      e_mem_size_1: return 1;
      e_mem_size_2: return 2;
      default:      return 4;
    endcase
  endfunction

  // Lanes from the offset up to the access size take their byte of wdata
  function automatic void apply_write(input logic [aw_lp-1:0] addr,
                                      input mem_msg_size_e size,
                                      input logic [dw_lp-1:0] wdata);
    int base;
    int offset;
    base   = int'(addr) / 4 * 4;
    offset = int'(addr) % 4;
    for (int lane = 0; lane < 4; lane++)
      if (lane >= offset && lane < offset + size_bytes(size))
        shadow_mem[base + lane] = wdata[8*lane +: 8];
  endfunction

  // Field at the offset repeated across all four lanes
  function automatic logic [dw_lp-1:0] expected_read(input logic [aw_lp-1:0] addr,
                                                      input mem_msg_size_e size);
    logic [dw_lp-1:0] word;
    int base;
    int offset;
    base   = int'(addr) / 4 * 4;
    offset = int'(addr) % 4;
    for (int lane = 0; lane < 4; lane++)
      word[8*lane +: 8] = shadow_mem[base + offset + lane % size_bytes(size)];
    return word;
  endfunction

  function automatic void add_entry(input mem_msg_type_e msg_type,
                                    input mem_msg_size_e size,
                                    input logic [aw_lp-1:0] addr,
                                    input logic [dw_lp-1:0] wdata);
    stim_entry_s entry;
    entry.header.msg_type = msg_type;
    entry.header.size     = size;
    entry.header.addr     = addr;
    entry.wdata           = wdata;
    if (msg_type == e_mem_wr)
    begin
      apply_write(addr, size, wdata);
      entry.exp_data = '0;
    end
    else
      entry.exp_data = expected_read(addr, size);
    stim_q.push_back(entry);
  endfunction

  task automatic build_table;
    mem_msg_type_e kind;
    mem_msg_size_e size;
    int word;
    int offset;
    // Word write and read back
    add_entry(e_mem_wr, e_mem_size_4, 32'h10, 32'hdead_beef);
    add_entry(e_mem_rd, e_mem_size_4, 32'h10, '0);
    // Narrow reads of a known word
    add_entry(e_mem_rd, e_mem_size_1, 32'h10, '0);
    add_entry(e_mem_rd, e_mem_size_1, 32'h11, '0);
    add_entry(e_mem_rd, e_mem_size_1, 32'h12, '0);
    add_entry(e_mem_rd, e_mem_size_1, 32'h13, '0);
    add_entry(e_mem_rd, e_mem_size_2, 32'h10, '0);
    add_entry(e_mem_rd, e_mem_size_2, 32'h11, '0);
    add_entry(e_mem_rd, e_mem_size_2, 32'h12, '0);
    // Byte writes at every offset
    add_entry(e_mem_wr, e_mem_size_4, 32'h20, 32'h0123_4567);
    add_entry(e_mem_wr, e_mem_size_1, 32'h20, 32'haabb_ccdd);
    add_entry(e_mem_rd, e_mem_size_4, 32'h20, '0);
    add_entry(e_mem_wr, e_mem_size_1, 32'h21, 32'h1234_5678);
    add_entry(e_mem_rd, e_mem_size_4, 32'h20, '0);
    add_entry(e_mem_wr, e_mem_size_1, 32'h22, 32'h9abc_def0);
    add_entry(e_mem_wr, e_mem_size_1, 32'h23, 32'h0f1e_2d3c);
    add_entry(e_mem_rd, e_mem_size_4, 32'h20, '0);
    // Halfword writes over the fill pattern
    add_entry(e_mem_wr, e_mem_size_2, 32'h24, 32'h5566_7788);
    add_entry(e_mem_rd, e_mem_size_4, 32'h24, '0);
    add_entry(e_mem_wr, e_mem_size_2, 32'h29, 32'h1122_3344);
    add_entry(e_mem_rd, e_mem_size_4, 32'h28, '0);
    add_entry(e_mem_wr, e_mem_size_2, 32'h2e, 32'h99aa_bbcc);
    add_entry(e_mem_rd, e_mem_size_4, 32'h2c, '0);
    add_entry(e_mem_rd, e_mem_size_1, 32'h47, '0);
    add_entry(e_mem_rd, e_mem_size_2, 32'h82, '0);
    add_entry(e_mem_rd, e_mem_size_4, 32'hfc, '0);
    // Mixed random traffic with halfwords kept inside one word
    for (int n = 0; n < random_entries_lp; n++)
    begin
      kind = ($urandom_range(1) == 0) ? e_mem_rd : e_mem_wr;
      case ($urandom_range(2))
        0:       size = e_mem_size_1;
        1:       size = e_mem_size_2;
        default: size = e_mem_size_4;
      endcase
      case (size)
        e_mem_size_1: offset = int'($urandom_range(3));
        e_mem_size_2: offset = int'($urandom_range(2));
        default:      offset = 0;
      endcase
      word = int'($urandom_range(`MEM_AXIL_MODEL_WORDS - 1));
      add_entry(kind, size, 32'(word * 4 + offset), $urandom);
    end
  endtask

  task automatic send_requests;
    mem_fwd_s req;
    for (int idx = 0; idx < stim_q.size(); idx++)
    begin
      req.header = stim_q[idx].header;
      req.data   = stim_q[idx].wdata;
      mem_fwd   <= req;
      mem_fwd_v <= 1'b1;
      @(negedge clk);
      while (!mem_fwd_ready)
        @(negedge clk);
      @(posedge clk);
    end
    mem_fwd_v <= 1'b0;
  endtask

  task automatic collect_responses;
    for (int idx = 0; idx < stim_q.size(); idx++)
    begin
      @(negedge clk);
      while (!(mem_rev_v && mem_rev_ready))
        @(negedge clk);
      check_rev_header(stim_q[idx].header, mem_rev.header);
      check_rev_data(stim_q[idx].exp_data, mem_rev.data);
    end
    rev_done = 1'b1;
  endtask

  // Random low periods of a few cycles on the response ready
  task automatic drive_backpressure;
    int hold;
    hold = 0;
    while (!rev_done)
    begin
      @(posedge clk);
      if (hold > 0)
      begin
        mem_rev_ready <= 1'b0;
        hold = hold - 1;
      end
      else if ($urandom_range(5) == 0)
      begin
        hold = int'($urandom_range(8, 2));
        mem_rev_ready <= 1'b0;
      end
      else
        mem_rev_ready <= 1'b1;
    end
  endtask

  task automatic check_no_extra_response;
    @(posedge clk);
    mem_rev_ready <= 1'b1;
    repeat (20)
    begin
      @(negedge clk);
      if (mem_rev_v)
      begin
        $display("Error at %0t: a response arrived after all requests were answered",
                 $time);
        abort_run();
      end
    end
  endtask

  initial
  begin
    reset         = 1'b1;
    mem_fwd       = '0;
    mem_fwd_v     = 1'b0;
    mem_rev_ready = 1'b0;
    rev_done      = 1'b0;
    addr_count    = 0;
    seed_value    = $urandom(32'ha2a6_f4d0);
    for (int a = 0; a < mem_bytes_lp; a++)
      shadow_mem[a] = 8'(a * 29 + 7);
    build_table();

    watchdog_ns = stim_q.size() * 200 * clk_period_lp;
    fork
      begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        abort_run();
      end
    join_none

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    fork
      send_requests();
      collect_responses();
      drive_backpressure();
    join

    check_no_extra_response();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* verilog/axil_read_issuer.sv */
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module axil_read_issuer
  import mem_axil_pkg::*;
  (
    input                                      clk_i
    , input                                    reset_i

    , input mem_fwd_s                          req_i
    , input                                    v_i
    , output logic                             ready_o

    , output axil_aw_s                         ar_o
    , output logic                             arvalid_o
    , input                                    arready_i

    , input axil_r_s                           r_i
    , input                                    rvalid_i
    , output logic                             rready_o

    , output logic [`MEM_AXIL_DATA_WIDTH-1:0]  data_o
    , output logic                             done_o
  );

  localparam int dw_lp = `MEM_AXIL_DATA_WIDTH;

  logic busy_r;
  logic ar_done_r;
  logic done_r;
  axil_aw_s ar_r;
  mem_msg_size_e size_r;
  logic [dw_lp-1:0] data_r;

  logic [dw_lp-1:0] shifted_li;
  logic [dw_lp-1:0] packed_li;
  logic accept_li;
  logic r_hs_li;

  // Addressed field moved to bit 0, then copied across the word
  always_comb
  begin
    shifted_li = r_i.data >> {ar_r.addr[axil_offset_width_lp-1:0], 3'b000};
    case (size_r)
      e_mem_size_1: packed_li = {(dw_lp/8){shifted_li[7:0]}};
      e_mem_size_2: packed_li = {(dw_lp/16){shifted_li[15:0]}};
      default:      packed_li = shifted_li;
    endcase
  end

  assign accept_li = v_i & ready_o;
  assign r_hs_li   = rvalid_i & rready_o;

  assign ready_o   = ~busy_r;
  assign arvalid_o = busy_r & ~ar_done_r;
  assign rready_o  = busy_r & ar_done_r;
  assign ar_o      = ar_r;
  assign data_o    = data_r;
  assign done_o    = done_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r    <= 1'b0;
      ar_done_r <= 1'b0;
      done_r    <= 1'b0;
    end
    else
    begin
      done_r <= r_hs_li;
      if (accept_li)
      begin
        busy_r    <= 1'b1;
        ar_done_r <= 1'b0;
      end
      else
      begin
        if (arvalid_o & arready_i)
          ar_done_r <= 1'b1;
        if (r_hs_li)
          busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_li)
    begin
      ar_r.addr <= req_i.header.addr;
      ar_r.prot <= 3'b000;
      size_r    <= req_i.header.size;
    end
    // rresp is not checked
    if (r_hs_li)
      data_r <= packed_li;
  end

endmodule

/* verilog/axil_write_issuer.sv */
`timescale 1ns/1ps

module axil_write_issuer
  import mem_axil_pkg::*;
  (
    input                clk_i
    , input              reset_i

    , input mem_fwd_s    req_i
    , input              v_i
    , output logic       ready_o

    , output axil_aw_s   aw_o
    , output logic       awvalid_o
    , input              awready_i

    , output axil_w_s    w_o
    , output logic       wvalid_o
    , input              wready_i

    , input [1:0]        bresp_i
    , input              bvalid_i
    , output logic       bready_o

    , output logic       done_o
  );

  logic busy_r;
  logic aw_done_r;
  logic w_done_r;
  logic done_r;
  axil_aw_s aw_r;
  axil_w_s w_r;

  logic [axil_offset_width_lp-1:0] offset_li;
  logic [axil_strb_width_lp-1:0] strb_li;
  logic accept_li;
  logic b_hs_li;

  // Strobe from size shifted up to the addressed byte lane
  always_comb
  begin
    offset_li = req_i.header.addr[axil_offset_width_lp-1:0];
    case (req_i.header.size)
      e_mem_size_1: strb_li = axil_strb_width_lp'(4'h1) << offset_li;
      e_mem_size_2: strb_li = axil_strb_width_lp'(4'h3) << offset_li;
      default:      strb_li = axil_strb_width_lp'(4'hF) << offset_li;
    endcase
  end

  assign accept_li = v_i & ready_o;
  // Write response code is ignored
  assign b_hs_li   = bvalid_i & bready_o;

  assign ready_o   = ~busy_r;
  assign awvalid_o = busy_r & ~aw_done_r;
  assign wvalid_o  = busy_r & ~w_done_r;
  assign bready_o  = busy_r & aw_done_r & w_done_r;
  assign aw_o      = aw_r;
  assign w_o       = w_r;
  assign done_o    = done_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r    <= 1'b0;
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
      done_r    <= 1'b0;
    end
    else
    begin
      done_r <= b_hs_li;
      if (accept_li)
      begin
        busy_r    <= 1'b1;
        aw_done_r <= 1'b0;
        w_done_r  <= 1'b0;
      end
      else
      begin
        // AW and W may complete in either order
        if (awvalid_o & awready_i)
          aw_done_r <= 1'b1;
        if (wvalid_o & wready_i)
          w_done_r <= 1'b1;
        if (b_hs_li)
          busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_li)
    begin
      aw_r.addr <= req_i.header.addr;
      aw_r.prot <= 3'b000;
      w_r.data  <= req_i.data;
      w_r.strb  <= strb_li;
    end
  end

endmodule

/* verilog/mem_axil_master.sv */
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module mem_axil_master
  import mem_axil_pkg::*;
  (
    input                clk_i
    , input              reset_i

    // Request stream
    , input mem_fwd_s    mem_fwd_i
    , input              mem_fwd_v_i
    , output logic       mem_fwd_ready_o

    // Response stream
    , output mem_rev_s   mem_rev_o
    , output logic       mem_rev_v_o
    , input              mem_rev_ready_i

    // AXI4-Lite write address
    , output axil_aw_s   m_axil_aw_o
    , output logic       m_axil_awvalid_o
    , input              m_axil_awready_i

    // AXI4-Lite write data
    , output axil_w_s    m_axil_w_o
    , output logic       m_axil_wvalid_o
    , input              m_axil_wready_i

    // AXI4-Lite write response
    , input [1:0]        m_axil_bresp_i
    , input              m_axil_bvalid_i
    , output logic       m_axil_bready_o

    // AXI4-Lite read address
    , output axil_aw_s   m_axil_ar_o
    , output logic       m_axil_arvalid_o
    , input              m_axil_arready_i

    // AXI4-Lite read data
    , input axil_r_s     m_axil_r_i
    , input              m_axil_rvalid_i
    , output logic       m_axil_rready_o
  );

  mem_fwd_s fifo_fwd_lo;
  logic fifo_fwd_v_lo;
  logic trk_ready_lo;

  mem_fwd_s eng_req_lo;
  logic wr_v_lo;
  logic wr_ready_lo;
  logic rd_v_lo;
  logic rd_ready_lo;
  logic wr_done_lo;
  logic rd_done_lo;
  logic [`MEM_AXIL_DATA_WIDTH-1:0] rd_data_lo;

  mem_rev_s trk_rev_lo;
  logic trk_rev_v_lo;
  logic fifo_rev_ready_lo;

  mem_two_fifo
    #(.payload_t(mem_fwd_s))
    fwd_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.data_i(mem_fwd_i)
     ,.v_i(mem_fwd_v_i)
     ,.ready_o(mem_fwd_ready_o)
     ,.data_o(fifo_fwd_lo)
     ,.v_o(fifo_fwd_v_lo)
     ,.ready_i(trk_ready_lo)
     );

  mem_txn_tracker
    tracker
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(fifo_fwd_lo)
     ,.req_v_i(fifo_fwd_v_lo)
     ,.req_ready_o(trk_ready_lo)
     ,.eng_req_o(eng_req_lo)
     ,.wr_v_o(wr_v_lo)
     ,.wr_ready_i(wr_ready_lo)
     ,.rd_v_o(rd_v_lo)
     ,.rd_ready_i(rd_ready_lo)
     ,.wr_done_i(wr_done_lo)
     ,.rd_done_i(rd_done_lo)
     ,.rd_data_i(rd_data_lo)
     ,.rev_o(trk_rev_lo)
     ,.rev_v_o(trk_rev_v_lo)
     ,.rev_ready_i(fifo_rev_ready_lo)
     );

  axil_write_issuer
    wr_engine
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(eng_req_lo)
     ,.v_i(wr_v_lo)
     ,.ready_o(wr_ready_lo)
     ,.aw_o(m_axil_aw_o)
     ,.awvalid_o(m_axil_awvalid_o)
     ,.awready_i(m_axil_awready_i)
     ,.w_o(m_axil_w_o)
     ,.wvalid_o(m_axil_wvalid_o)
     ,.wready_i(m_axil_wready_i)
     ,.bresp_i(m_axil_bresp_i)
     ,.bvalid_i(m_axil_bvalid_i)
     ,.bready_o(m_axil_bready_o)
     ,.done_o(wr_done_lo)
     );

  axil_read_issuer
    rd_engine
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(eng_req_lo)
     ,.v_i(rd_v_lo)
     ,.ready_o(rd_ready_lo)
     ,.ar_o(m_axil_ar_o)
     ,.arvalid_o(m_axil_arvalid_o)
     ,.arready_i(m_axil_arready_i)
     ,.r_i(m_axil_r_i)
     ,.rvalid_i(m_axil_rvalid_i)
     ,.rready_o(m_axil_rready_o)
     ,.data_o(rd_data_lo)
     ,.done_o(rd_done_lo)
     );

  mem_two_fifo
    #(.payload_t(mem_rev_s))
    rev_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.data_i(trk_rev_lo)
     ,.v_i(trk_rev_v_lo)
     ,.ready_o(fifo_rev_ready_lo)
     ,.data_o(mem_rev_o)
     ,.v_o(mem_rev_v_o)
     ,.ready_i(mem_rev_ready_i)
     );

endmodule

/* verilog/mem_axil_pkg.sv */
`include "mem_axil_cfg.svh"

package mem_axil_pkg;

  // One strobe bit per data byte
  localparam int axil_strb_width_lp = `MEM_AXIL_DATA_WIDTH / 8;
  localparam int axil_offset_width_lp = $clog2(axil_strb_width_lp);

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00
    , e_mem_wr = 2'b01
  } mem_msg_type_e;

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0]
  {
    e_mem_size_1 = 2'b00
    , e_mem_size_2 = 2'b01
    , e_mem_size_4 = 2'b10
  } mem_msg_size_e;

  typedef struct packed
  {
    mem_msg_type_e                   msg_type;
    mem_msg_size_e                   size;
    logic [`MEM_AXIL_ADDR_WIDTH-1:0] addr;
  } mem_header_s;

  typedef struct packed
  {
    mem_header_s                     header;
    logic [`MEM_AXIL_DATA_WIDTH-1:0] data;
  } mem_fwd_s;

  typedef struct packed
  {
    mem_header_s                     header;
    logic [`MEM_AXIL_DATA_WIDTH-1:0] data;
  } mem_rev_s;

  // Shared by AW and AR
  typedef struct packed
  {
    logic [`MEM_AXIL_ADDR_WIDTH-1:0] addr;
    logic [2:0]                      prot;
  } axil_aw_s;

  typedef struct packed
  {
    logic [`MEM_AXIL_DATA_WIDTH-1:0] data;
    logic [axil_strb_width_lp-1:0]   strb;
  } axil_w_s;

  typedef struct packed
  {
    logic [`MEM_AXIL_DATA_WIDTH-1:0] data;
    logic [1:0]                      resp;
  } axil_r_s;

endpackage

/* verilog/mem_two_fifo.sv */
`timescale 1ns/1ps

module mem_two_fifo
  import mem_axil_pkg::*;
  #(parameter type payload_t = mem_fwd_s)
  (
    input              clk_i
    , input            reset_i

    , input payload_t  data_i
    , input            v_i
    , output logic     ready_o

    , output payload_t data_o
    , output logic     v_o
    , input            ready_i
  );

  payload_t mem_r [1:0];

  logic wptr_r;
  logic rptr_r;
  logic full_r;
  logic empty_r;
  logic enq_li;
  logic deq_li;

  // Ready only from the registered full flag, so no path from ready_i
  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  assign enq_li = v_i & ready_o;
  assign deq_li = v_o & ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end
    else
    begin
      if (enq_li)
        wptr_r <= ~wptr_r;
      if (deq_li)
        rptr_r <= ~rptr_r;

      // Occupancy only changes when exactly one side moves
      if (enq_li & ~deq_li)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end
      else if (deq_li & ~enq_li)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq_li)
      mem_r[wptr_r] <= data_i;
  end

endmodule

/* verilog/mem_txn_tracker.sv */
`timescale 1ns/1ps

`include "mem_axil_cfg.svh"

module mem_txn_tracker
  import mem_axil_pkg::*;
  (
    input                                    clk_i
    , input                                  reset_i

    , input mem_fwd_s                        req_i
    , input                                  req_v_i
    , output logic                           req_ready_o

    , output mem_fwd_s                       eng_req_o
    , output logic                           wr_v_o
    , input                                  wr_ready_i
    , output logic                           rd_v_o
    , input                                  rd_ready_i

    , input                                  wr_done_i
    , input                                  rd_done_i
    , input [`MEM_AXIL_DATA_WIDTH-1:0]       rd_data_i

    , output mem_rev_s                       rev_o
    , output logic                           rev_v_o
    , input                                  rev_ready_i
  );

  typedef enum logic [1:0]
  {
    e_idle
    , e_busy
    , e_respond
  } state_e;

  state_e state_r;
  state_e state_n;
  mem_header_s header_r;
  logic [`MEM_AXIL_DATA_WIDTH-1:0] data_r;

  logic is_wr_li;
  logic sel_ready_li;
  logic accept_li;
  logic done_li;

  assign is_wr_li     = (req_i.header.msg_type == e_mem_wr);
  assign sel_ready_li = is_wr_li ? wr_ready_i : rd_ready_i;

  // Take a request only when the engine it needs can take it too
  assign req_ready_o = (state_r == e_idle) & sel_ready_li;
  assign accept_li   = req_v_i & req_ready_o;
  assign wr_v_o      = (state_r == e_idle) & req_v_i & is_wr_li;
  assign rd_v_o      = (state_r == e_idle) & req_v_i & ~is_wr_li;
  assign eng_req_o   = req_i;

  assign done_li = wr_done_i | rd_done_i;
  assign rev_v_o = (state_r == e_respond);

  always_comb
  begin
    rev_o.header = header_r;
    rev_o.data   = data_r;
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:    if (accept_li) state_n = e_busy;
      e_busy:    if (done_li) state_n = e_respond;
      e_respond: if (rev_ready_i) state_n = e_idle;
      default:   state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_li)
      header_r <= req_i.header;
    // Writes answer with a zero data word
    if ((state_r == e_busy) & done_li)
      data_r <= rd_done_i ? rd_data_i : '0;
  end

endmodule
